// File: Makefile
VERILATOR       ?= verilator
TOP             ?= mci_tb
FILELIST        ?= filelist.f
BUILD_DIR       ?= obj_dir
JOBS            ?= 4
VERILATOR_FLAGS ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VERILATOR_FLAGS) -j $(JOBS) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)

# Run from the project root so the stimulus path resolves
sim: build
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: filelist.f
hw/mci_pkg.sv
hw/mci_apb_regs.sv
hw/mci_boot_seqr.sv
hw/mci_wdt.sv
hw/mci_top.sv
verif/mci_checker.sv
verif/mci_tb.sv

// File: hw/mci_apb_regs.sv
`timescale 1ns/100ps

module mci_apb_regs
    import mci_pkg::*;
#(
    parameter int GENERIC_W = 32
) (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  apb_req_t             apb_req_i,
    output apb_rsp_t             apb_rsp_o,
    output wdt_cfg_t             wdt_cfg_o,
    input  wdt_evt_t             wdt_evt_i,
    output boot_ctrl_t           boot_ctrl_o,
    input  boot_status_t         boot_status_i,
    input  logic [DATA_W-1:0]    agg_error_fatal_i,
    input  logic [DATA_W-1:0]    agg_error_non_fatal_i,
    input  logic [GENERIC_W-1:0] generic_in_i,
    output logic [GENERIC_W-1:0] generic_out_o,
    output logic                 all_error_fatal_o,
    output logic                 all_error_non_fatal_o,
    output logic                 mci_intr_o,
    output logic                 nmi_intr_o
);

    mci_reg_addr_e     reg_addr;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] rdata;
    logic              acc_en;
    logic              addr_hit;
    logic              addr_ro;
    logic              wr_en;

    // Storage
    logic              boot_go_q;
    logic              rst_req_q;
    logic              wdt_en_q;
    logic              wdt_restart_q;
    logic [DATA_W-1:0] wdt_period1_q;
    logic [DATA_W-1:0] wdt_period2_q;
    logic [1:0]        wdt_sts_q;
    logic [DATA_W-1:0] fatal_sts_q;
    logic [DATA_W-1:0] fatal_mask_q;
    logic [DATA_W-1:0] nonfatal_sts_q;
    logic [DATA_W-1:0] nonfatal_mask_q;
    logic [GENERIC_W-1:0] generic_out_q;

    // W1C clear vectors
    logic [DATA_W-1:0] fatal_clr;
    logic [DATA_W-1:0] nonfatal_clr;
    logic [1:0]        wdt_clr;

    //////////////////////////////////////////////////
    // APB decode and read mux
    //////////////////////////////////////////////////
    assign reg_addr = mci_reg_addr_e'(apb_req_i.paddr);
    assign wdata    = apb_req_i.pwdata;
    assign acc_en   = apb_req_i.psel & apb_req_i.penable;

    always_comb begin
        addr_hit = 1'b1;
        addr_ro  = 1'b0;
        rdata    = '0;
        case (reg_addr)
            BOOT_GO:           rdata[0] = boot_go_q;
            RESET_REQUEST:     rdata[0] = rst_req_q;
            WDT_EN:            rdata[0] = wdt_en_q;
            WDT_RESTART:       rdata[0] = wdt_restart_q;
            WDT_PERIOD1:       rdata = wdt_period1_q;
            WDT_PERIOD2:       rdata = wdt_period2_q;
            WDT_STATUS:        rdata[1:0] = wdt_sts_q;
            ERR_FATAL_STS:     rdata = fatal_sts_q;
            ERR_FATAL_MASK:    rdata = fatal_mask_q;
            ERR_NONFATAL_STS:  rdata = nonfatal_sts_q;
            ERR_NONFATAL_MASK: rdata = nonfatal_mask_q;
            GENERIC_OUT:       rdata[GENERIC_W-1:0] = generic_out_q;
            GENERIC_IN: begin
                rdata[GENERIC_W-1:0] = generic_in_i;
                addr_ro = 1'b1;
            end
            BOOT_STATUS: begin
                rdata[2:0] = boot_status_i.state;
                rdata[8]   = boot_status_i.mcu_reset_once;
                addr_ro    = 1'b1;
            end
            default:           addr_hit = 1'b0;
        endcase
    end

    // Writes to read-only or unmapped offsets are dropped
    assign wr_en = acc_en & apb_req_i.pwrite & addr_hit & ~addr_ro;

    assign apb_rsp_o.prdata  = rdata;
    assign apb_rsp_o.pready  = acc_en;
    assign apb_rsp_o.pslverr = acc_en & (~addr_hit | (apb_req_i.pwrite & addr_ro));

    assign fatal_clr    = (wr_en && reg_addr == ERR_FATAL_STS) ? wdata : '0;
    assign nonfatal_clr = (wr_en && reg_addr == ERR_NONFATAL_STS) ? wdata : '0;
    assign wdt_clr      = (wr_en && reg_addr == WDT_STATUS) ? wdata[1:0] : 2'b00;

    //////////////////////////////////////////////////
    // Software-written fields
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            boot_go_q       <= 1'b0;
            rst_req_q       <= 1'b0;
            wdt_en_q        <= 1'b0;
            wdt_restart_q   <= 1'b0;
            wdt_period1_q   <= '0;
            wdt_period2_q   <= '0;
            fatal_mask_q    <= '0;
            nonfatal_mask_q <= '0;
            generic_out_q   <= '0;
        end else begin
            // One-cycle strobes
            rst_req_q     <= wr_en && reg_addr == RESET_REQUEST && wdata[0];
            wdt_restart_q <= wr_en && reg_addr == WDT_RESTART && wdata[0];
            if (wr_en) begin
                case (reg_addr)
                    BOOT_GO:           boot_go_q       <= wdata[0];
                    WDT_EN:            wdt_en_q        <= wdata[0];
                    WDT_PERIOD1:       wdt_period1_q   <= wdata;
                    WDT_PERIOD2:       wdt_period2_q   <= wdata;
                    ERR_FATAL_MASK:    fatal_mask_q    <= wdata;
                    ERR_NONFATAL_MASK: nonfatal_mask_q <= wdata;
                    GENERIC_OUT:       generic_out_q   <= wdata[GENERIC_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    // Sticky status; a hardware set beats a same-cycle clear
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wdt_sts_q             <= 2'b00;
            fatal_sts_q           <= '0;
            nonfatal_sts_q        <= '0;
            all_error_fatal_o     <= 1'b0;
            all_error_non_fatal_o <= 1'b0;
            mci_intr_o            <= 1'b0;
            nmi_intr_o            <= 1'b0;
        end else begin
            wdt_sts_q[0]   <= (wdt_sts_q[0] & ~wdt_clr[0]) | wdt_evt_i.t1_timeout_p;
            wdt_sts_q[1]   <= (wdt_sts_q[1] & ~wdt_clr[1]) | wdt_evt_i.t2_timeout_p;
            fatal_sts_q    <= (fatal_sts_q & ~fatal_clr) | agg_error_fatal_i;
            nonfatal_sts_q <= (nonfatal_sts_q & ~nonfatal_clr) | agg_error_non_fatal_i;
            all_error_fatal_o     <= |(fatal_sts_q & ~fatal_mask_q);
            all_error_non_fatal_o <= |(nonfatal_sts_q & ~nonfatal_mask_q);
            mci_intr_o <= wdt_sts_q[0];
            nmi_intr_o <= wdt_sts_q[1];
        end
    end

    assign wdt_cfg_o.en      = wdt_en_q;
    assign wdt_cfg_o.restart = wdt_restart_q;
    assign wdt_cfg_o.period1 = wdt_period1_q;
    assign wdt_cfg_o.period2 = wdt_period2_q;

    assign boot_ctrl_o.mcu_boot_go = boot_go_q;
    assign boot_ctrl_o.mcu_rst_req = rst_req_q;

    assign generic_out_o = generic_out_q;

endmodule

// File: hw/mci_boot_seqr.sv
`timescale 1ns/100ps

module mci_boot_seqr
    import mci_pkg::*;
#(
    parameter int MCU_RST_CNT_W = 4
) (
    input  logic         clk,
    input  logic         arst_n_i,
    input  boot_ctrl_t   boot_ctrl_i,
    input  logic         lc_done_i,
    input  logic         fc_done_i,
    output logic         lc_init_o,
    output logic         fc_init_o,
    output logic         cptra_rst_b_o,
    output logic         mcu_rst_b_o,
    output boot_status_t boot_status_o
);

    mci_boot_state_e          state_q;
    mci_boot_state_e          state_nxt;
    logic [MCU_RST_CNT_W-1:0] rst_cnt_q;
    logic                     rst_cnt_done;
    logic                     mcu_reset_once_q;

    // Warm reset lasts until the counter wraps
    assign rst_cnt_done = &rst_cnt_q;

    always_comb begin
        state_nxt = state_q;
        case (state_q)
            BOOT_IDLE:    state_nxt = BOOT_LCC;
            BOOT_LCC:     if (lc_done_i) state_nxt = BOOT_FUSE;
            BOOT_FUSE:    if (fc_done_i) state_nxt = BOOT_CPTRA;
            BOOT_CPTRA:   if (boot_ctrl_i.mcu_boot_go) state_nxt = BOOT_MCU_UP;
            BOOT_MCU_UP:  if (boot_ctrl_i.mcu_rst_req) state_nxt = BOOT_MCU_RST;
            BOOT_MCU_RST: if (rst_cnt_done) state_nxt = BOOT_MCU_UP;
            default:      state_nxt = BOOT_IDLE;
        endcase
    end

    //////////////////////////////////////////////////
    // State, counter and registered reset outputs
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q          <= BOOT_IDLE;
            rst_cnt_q        <= '0;
            mcu_reset_once_q <= 1'b0;
            lc_init_o        <= 1'b0;
            fc_init_o        <= 1'b0;
            cptra_rst_b_o    <= 1'b0;
            mcu_rst_b_o      <= 1'b0;
        end else begin
            state_q   <= state_nxt;
            rst_cnt_q <= (state_q == BOOT_MCU_RST) ? rst_cnt_q + 1'b1 : '0;
            if (state_q == BOOT_MCU_RST && rst_cnt_done) begin
                mcu_reset_once_q <= 1'b1;
            end
            // Decoded from next state so the outputs line up with state_q
            lc_init_o     <= (state_nxt == BOOT_LCC);
            fc_init_o     <= (state_nxt == BOOT_FUSE);
            cptra_rst_b_o <= (state_nxt == BOOT_CPTRA) || (state_nxt == BOOT_MCU_UP) ||
                             (state_nxt == BOOT_MCU_RST);
            mcu_rst_b_o   <= (state_nxt == BOOT_MCU_UP);
        end
    end

    assign boot_status_o.state          = state_q;
    assign boot_status_o.mcu_reset_once = mcu_reset_once_q;

endmodule

// File: hw/mci_pkg.sv
package mci_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////
    localparam int DATA_W = 32;
    localparam int ADDR_W = 8;

    // CSR byte offsets
    typedef enum logic [ADDR_W-1:0] {
        BOOT_GO           = 8'h00,
        RESET_REQUEST     = 8'h04,
        WDT_EN            = 8'h08,
        WDT_RESTART       = 8'h0C,
        WDT_PERIOD1       = 8'h10,
        WDT_PERIOD2       = 8'h14,
        WDT_STATUS        = 8'h18,
        ERR_FATAL_STS     = 8'h1C,
        ERR_FATAL_MASK    = 8'h20,
        ERR_NONFATAL_STS  = 8'h24,
        ERR_NONFATAL_MASK = 8'h28,
        GENERIC_OUT       = 8'h2C,
        GENERIC_IN        = 8'h30,
        BOOT_STATUS       = 8'h34
    } mci_reg_addr_e;

    // Boot FSM states as reported in BOOT_STATUS
    typedef enum logic [2:0] {
        BOOT_IDLE    = 3'd0,
        BOOT_LCC     = 3'd1,
        BOOT_FUSE    = 3'd2,
        BOOT_CPTRA   = 3'd3,
        BOOT_MCU_UP  = 3'd4,
        BOOT_MCU_RST = 3'd5
    } mci_boot_state_e;

    //////////////////////////////////////////////////
    // Bundles between blocks
    //////////////////////////////////////////////////
    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [ADDR_W-1:0] paddr;
        logic [DATA_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic              en;
        logic              restart;
        logic [DATA_W-1:0] period1;
        logic [DATA_W-1:0] period2;
    } wdt_cfg_t;

    // Single-cycle timeout strobes
    typedef struct packed {
        logic t1_timeout_p;
        logic t2_timeout_p;
    } wdt_evt_t;

    typedef struct packed {
        logic mcu_boot_go;
        logic mcu_rst_req;
    } boot_ctrl_t;

    typedef struct packed {
        mci_boot_state_e state;
        logic            mcu_reset_once;
    } boot_status_t;

endpackage

// File: hw/mci_top.sv
`timescale 1ns/100ps

module mci_top
    import mci_pkg::*;
#(
    parameter int MCU_RST_CNT_W = 4,
    parameter int GENERIC_W     = 32
) (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  apb_req_t             apb_req_i,
    output apb_rsp_t             apb_rsp_o,
    input  logic                 lc_done_i,
    output logic                 lc_init_o,
    input  logic                 fc_done_i,
    output logic                 fc_init_o,
    output logic                 cptra_rst_b_o,
    output logic                 mcu_rst_b_o,
    input  logic [DATA_W-1:0]    agg_error_fatal_i,
    input  logic [DATA_W-1:0]    agg_error_non_fatal_i,
    input  logic [GENERIC_W-1:0] generic_in_i,
    output logic [GENERIC_W-1:0] generic_out_o,
    output logic                 all_error_fatal_o,
    output logic                 all_error_non_fatal_o,
    output logic                 mci_intr_o,
    output logic                 nmi_intr_o
);

    wdt_cfg_t     wdt_cfg;
    wdt_evt_t     wdt_evt;
    boot_ctrl_t   boot_ctrl;
    boot_status_t boot_status;

    // CSR bank behind APB
    mci_apb_regs #(
        .GENERIC_W(GENERIC_W)
    ) i_mci_apb_regs (
        .clk                  (clk),
        .arst_n_i             (arst_n_i),
        .apb_req_i            (apb_req_i),
        .apb_rsp_o            (apb_rsp_o),
        .wdt_cfg_o            (wdt_cfg),
        .wdt_evt_i            (wdt_evt),
        .boot_ctrl_o          (boot_ctrl),
        .boot_status_i        (boot_status),
        .agg_error_fatal_i    (agg_error_fatal_i),
        .agg_error_non_fatal_i(agg_error_non_fatal_i),
        .generic_in_i         (generic_in_i),
        .generic_out_o        (generic_out_o),
        .all_error_fatal_o    (all_error_fatal_o),
        .all_error_non_fatal_o(all_error_non_fatal_o),
        .mci_intr_o           (mci_intr_o),
        .nmi_intr_o           (nmi_intr_o)
    );

    mci_boot_seqr #(
        .MCU_RST_CNT_W(MCU_RST_CNT_W)
    ) i_boot_seqr (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .boot_ctrl_i  (boot_ctrl),
        .lc_done_i    (lc_done_i),
        .fc_done_i    (fc_done_i),
        .lc_init_o    (lc_init_o),
        .fc_init_o    (fc_init_o),
        .cptra_rst_b_o(cptra_rst_b_o),
        .mcu_rst_b_o  (mcu_rst_b_o),
        .boot_status_o(boot_status)
    );

    mci_wdt i_mci_wdt (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .wdt_cfg_i(wdt_cfg),
        .wdt_evt_o(wdt_evt)
    );

endmodule

// File: hw/mci_wdt.sv
`timescale 1ns/100ps

module mci_wdt
    import mci_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n_i,
    input  wdt_cfg_t wdt_cfg_i,
    output wdt_evt_t wdt_evt_o
);

    // Which stage is counting, or both halted after the second timeout
    typedef enum logic [1:0] {
        WDT_STAGE1 = 2'd0,
        WDT_STAGE2 = 2'd1,
        WDT_HALT   = 2'd2
    } wdt_stage_e;

    wdt_stage_e        stage_q;
    logic [DATA_W-1:0] cnt1_q;
    logic [DATA_W-1:0] cnt2_q;
    logic              run;
    logic              t1_hit;
    logic              t2_hit;

    assign run    = wdt_cfg_i.en & ~wdt_cfg_i.restart;
    assign t1_hit = run && stage_q == WDT_STAGE1 && cnt1_q == wdt_cfg_i.period1;
    assign t2_hit = run && stage_q == WDT_STAGE2 && cnt2_q == wdt_cfg_i.period2;

    //////////////////////////////////////////////////
    // Cascaded counters
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            stage_q <= WDT_STAGE1;
            cnt1_q  <= '0;
            cnt2_q  <= '0;
        end else if (!run) begin
            stage_q <= WDT_STAGE1;
            cnt1_q  <= '0;
            cnt2_q  <= '0;
        end else begin
            case (stage_q)
                WDT_STAGE1: begin
                    if (t1_hit) begin
                        stage_q <= WDT_STAGE2;
                        cnt2_q  <= '0;
                    end else begin
                        cnt1_q <= cnt1_q + 1'b1;
                    end
                end
                WDT_STAGE2: begin
                    if (t2_hit) begin
                        stage_q <= WDT_HALT;
                    end else begin
                        cnt2_q <= cnt2_q + 1'b1;
                    end
                end
                // Halted until restart or disable
                default: ;
            endcase
        end
    end

    assign wdt_evt_o.t1_timeout_p = t1_hit;
    assign wdt_evt_o.t2_timeout_p = t2_hit;

endmodule

// File: verif/mci_checker.sv
`timescale 1ns/100ps

module mci_checker
    import mci_pkg::*;
(
    input logic     clk,
    input logic     arst_n_i,
    input apb_req_t apb_req_i,
    input apb_rsp_t apb_rsp_i,
    input logic     lc_init_i,
    input logic     fc_init_i,
    input logic     cptra_rst_b_i,
    input logic     mcu_rst_b_i,
    input logic     mci_intr_i,
    input logic     nmi_intr_i
);

    // Boot FSM sits in at most one init phase
    init_exclusive_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(lc_init_i && fc_init_i))
        else $error("lc_init_o and fc_init_o high together");

    mcu_after_cptra_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        mcu_rst_b_i |-> cptra_rst_b_i)
        else $error("MCU out of reset while core still in reset");

    // Error response only in a live access phase
    slverr_in_access_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        apb_rsp_i.pslverr |-> (apb_req_i.psel && apb_req_i.penable && apb_rsp_i.pready))
        else $error("pslverr outside an APB access phase");

    nmi_after_intr_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        $rose(nmi_intr_i) |-> mci_intr_i)
        else $error("nmi_intr_o rose without mci_intr_o");

endmodule

bind mci_top mci_checker i_mci_checker (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .apb_req_i    (apb_req_i),
    .apb_rsp_i    (apb_rsp_o),
    .lc_init_i    (lc_init_o),
    .fc_init_i    (fc_init_o),
    .cptra_rst_b_i(cptra_rst_b_o),
    .mcu_rst_b_i  (mcu_rst_b_o),
    .mci_intr_i   (mci_intr_o),
    .nmi_intr_i   (nmi_intr_o)
);

// File: verif/mci_stim.txt
# op sel data expected, all numbers hex; W: addr wdata pslverr, R: addr pslverr rdata
# S: input(0 lc_done 1 fc_done 2 agg_fatal 3 agg_nonfatal 4 generic_in) value; C: 0 cycles; P: output exp
# boot flow
C 0 2 0
P 0 0 1
P 1 0 0
P 2 0 0
S 0 1 0
C 0 2 0
P 0 0 0
P 1 0 1
S 1 1 0
C 0 2 0
P 1 0 0
P 2 0 1
P 3 0 0
W 00 1 0
C 0 2 0
P 3 0 1
R 34 0 4
# warm reset
W 04 1 0
C 0 2 0
P 3 0 0
C 0 14 0
P 3 0 1
R 34 0 104
# watchdog
W 10 14 0
W 14 1E 0
W 08 1 0
C 0 A 0
R 18 0 0
C 0 F 0
R 18 0 1
P 7 0 1
P 8 0 0
C 0 28 0
R 18 0 3
P 8 0 1
W 0C 1 0
W 18 3 0
R 18 0 0
W 08 0 0
C 0 2 0
P 7 0 0
P 8 0 0
# error aggregation
P 5 0 0
S 2 5 0
C 0 2 0
P 5 0 1
W 20 5 0
C 0 2 0
P 5 0 0
S 2 0 0
W 1C 1 0
R 1C 0 4
W 20 0 0
C 0 2 0
P 5 0 1
P 6 0 0
S 3 5 0
C 0 2 0
P 6 0 1
W 28 5 0
C 0 2 0
P 6 0 0
S 3 0 0
W 24 1 0
R 24 0 4
# generic wires and APB errors
W 2C A5A51234 0
P 4 0 A5A51234
R 2C 0 A5A51234
S 4 5A5A0F0F 0
R 30 0 5A5A0F0F
R 3C 1 0
W 30 1 1
W 3C 12345678 1
R 30 0 5A5A0F0F

// File: verif/mci_tb.sv
`timescale 1ns/100ps

module mci_tb
    import mci_pkg::*;
();

    localparam int    CLK_PERIOD    = 10;
    localparam int    RESET_CYCLES  = 5;
    localparam int    APB_CYCLES    = 4;
    localparam int    MARGIN_CYCLES = 200;
    localparam string STIM_FILE     = "verif/mci_stim.txt";

    // Opcode letters of the stimulus file
    typedef enum logic [7:0] {
        OP_WRITE = "W",
        OP_READ  = "R",
        OP_SET   = "S",
        OP_WAIT  = "C",
        OP_PROBE = "P"
    } stim_op_e;

    typedef struct packed {
        stim_op_e    op;
        logic [31:0] sel;
        logic [31:0] data;
        logic [31:0] expected;
    } stim_cmd_t;

    logic        clk;
    logic        arst_n_i;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic        lc_done;
    logic        fc_done;
    logic [31:0] agg_fatal;
    logic [31:0] agg_non_fatal;
    logic [31:0] generic_in;
    logic        lc_init;
    logic        fc_init;
    logic        cptra_rst_b;
    logic        mcu_rst_b;
    logic [31:0] generic_out;
    logic        err_fatal;
    logic        err_non_fatal;
    logic        mci_intr;
    logic        nmi_intr;

    stim_cmd_t   cmds[$];
    int          max_wait;
    bit          stim_loaded = 1'b0;

    mci_top DUT (
        .clk                  (clk),
        .arst_n_i             (arst_n_i),
        .apb_req_i            (apb_req),
        .apb_rsp_o            (apb_rsp),
        .lc_done_i            (lc_done),
        .lc_init_o            (lc_init),
        .fc_done_i            (fc_done),
        .fc_init_o            (fc_init),
        .cptra_rst_b_o        (cptra_rst_b),
        .mcu_rst_b_o          (mcu_rst_b),
        .agg_error_fatal_i    (agg_fatal),
        .agg_error_non_fatal_i(agg_non_fatal),
        .generic_in_i         (generic_in),
        .generic_out_o        (generic_out),
        .all_error_fatal_o    (err_fatal),
        .all_error_non_fatal_o(err_non_fatal),
        .mci_intr_o           (mci_intr),
        .nmi_intr_o           (nmi_intr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Failure reporting and value check
    //////////////////////////////////////////////////
    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1, "Run aborted");
    endtask

    task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Fail at %0t: %s, got 0x%08h, expected 0x%08h",
                                        $time, what, actual, expected));
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus file
    //////////////////////////////////////////////////
    task automatic load_stimulus();
        int               fd;
        int               n;
        bit               done;
        logic [8*16-1:0]  tok;
        logic [8*256-1:0] rest;
        logic [31:0]      sel;
        logic [31:0]      data;
        logic [31:0]      expected;
        stim_cmd_t        cmd;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            stop_with_failure($sformatf("Cannot open stimulus file %s", STIM_FILE));
        end
        done     = 1'b0;
        max_wait = 0;
        while (!done) begin
            n = $fscanf(fd, "%s", tok);
            if (n != 1) begin
                done = 1'b1;
            end else if (tok[7:0] == "#") begin
                // Comment line
                n = $fgets(rest, fd);
            end else begin
                n = $fscanf(fd, "%h %h %h", sel, data, expected);
                if (n != 3 ||
                    !(tok[7:0] inside {OP_WRITE, OP_READ, OP_SET, OP_WAIT, OP_PROBE})) begin
                    stop_with_failure($sformatf("Bad stimulus line after command %0d",
                                                cmds.size()));
                end
                cmd.op       = stim_op_e'(tok[7:0]);
                cmd.sel      = sel;
                cmd.data     = data;
                cmd.expected = expected;
                if (cmd.op == OP_WAIT && int'(cmd.data) > max_wait) begin
                    max_wait = int'(cmd.data);
                end
                cmds.push_back(cmd);
            end
        end
        $fclose(fd);
        stim_loaded = 1'b1;
    endtask

    //////////////////////////////////////////////////
    // APB driver and command execution
    //////////////////////////////////////////////////
    task automatic apb_access(input logic is_write, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        @(posedge clk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= is_write;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= wdata;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        // Response is combinational in the access phase
        @(negedge clk);
        compare({31'b0, apb_rsp.pready}, 32'h1, "pready in access phase");
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge clk);
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= 1'b0;
    endtask

    task automatic drive_input(input logic [31:0] sel, input logic [31:0] value);
        @(posedge clk);
        case (sel)
            32'd0:   lc_done       <= value[0];
            32'd1:   fc_done       <= value[0];
            32'd2:   agg_fatal     <= value;
            32'd3:   agg_non_fatal <= value;
            32'd4:   generic_in    <= value;
            default: stop_with_failure($sformatf("Unknown input selector %0d", sel));
        endcase
    endtask

    task automatic check_output(input logic [31:0] sel, input logic [31:0] expected,
                                input int idx);
        logic [31:0] actual;
        @(negedge clk);
        actual = '0;
        // Top-level outputs by P selector
        case (sel)
            32'd0:   actual[0] = lc_init;
            32'd1:   actual[0] = fc_init;
            32'd2:   actual[0] = cptra_rst_b;
            32'd3:   actual[0] = mcu_rst_b;
            32'd4:   actual    = generic_out;
            32'd5:   actual[0] = err_fatal;
            32'd6:   actual[0] = err_non_fatal;
            32'd7:   actual[0] = mci_intr;
            32'd8:   actual[0] = nmi_intr;
            default: stop_with_failure($sformatf("Unknown output selector %0d", sel));
        endcase
        compare(actual, expected, $sformatf("cmd %0d output selector %0d", idx, sel));
    endtask

    task automatic run_command(input stim_cmd_t cmd, input int idx);
        logic [31:0] rdata;
        logic        err;
        case (cmd.op)
            OP_WRITE: begin
                apb_access(1'b1, cmd.sel[7:0], cmd.data, rdata, err);
                compare({31'b0, err}, cmd.expected,
                        $sformatf("cmd %0d pslverr on write to 0x%02h", idx, cmd.sel[7:0]));
            end
            OP_READ: begin
                apb_access(1'b0, cmd.sel[7:0], 32'h0, rdata, err);
                compare({31'b0, err}, cmd.data,
                        $sformatf("cmd %0d pslverr on read of 0x%02h", idx, cmd.sel[7:0]));
                compare(rdata, cmd.expected,
                        $sformatf("cmd %0d read data of 0x%02h", idx, cmd.sel[7:0]));
            end
            OP_SET:   drive_input(cmd.sel, cmd.data);
            OP_WAIT:  repeat (cmd.data) @(posedge clk);
            OP_PROBE: check_output(cmd.sel, cmd.expected, idx);
            default:  stop_with_failure($sformatf("Unknown opcode in command %0d", idx));
        endcase
    endtask

    initial begin
        arst_n_i      = 1'b0;
        apb_req       = '0;
        lc_done       = 1'b0;
        fc_done       = 1'b0;
        agg_fatal     = '0;
        agg_non_fatal = '0;
        generic_in    = '0;
        load_stimulus();
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n_i <= 1'b1;
        foreach (cmds[i]) begin
            run_command(cmds[i], i);
        end
        if (cmds.size() > 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            stop_with_failure("Stimulus file held no commands");
        end
    end

    // Run limit scales with the command count and the longest wait
    initial begin
        int limit_cycles;
        wait (stim_loaded);
        limit_cycles = RESET_CYCLES + cmds.size() * (max_wait + APB_CYCLES) + MARGIN_CYCLES;
        repeat (limit_cycles) @(posedge clk);
        stop_with_failure($sformatf("Timeout: stimulus not finished after %0d cycles",
                                    limit_cycles));
    end

endmodule
